//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and address widths
`define CPU_DATA_WIDTH 32
`define CPU_HALF_WIDTH 16
`define CPU_SHIFT_WIDTH 5
`define CPU_INST_ADDR_WIDTH 16
`define CPU_DATA_ADDR_WIDTH 16
`define CPU_REG_COUNT 32
`define CPU_REG_ADDR_WIDTH 5

// opcodes, instruction bits 31..27
`define OP_ADD 5'd0
`define OP_ADDI 5'd1
`define OP_SUB 5'd2
`define OP_AND 5'd3
`define OP_ANDI 5'd4
`define OP_OR 5'd5
`define OP_ORI 5'd6
`define OP_XOR 5'd7
`define OP_SLL 5'd8
`define OP_SRL 5'd9
`define OP_SRA 5'd10
`define OP_LLI 5'd11
`define OP_LUI 5'd12
`define OP_LWO 5'd15
`define OP_SWO 5'd16
`define OP_B 5'd17
`define OP_BL 5'd18
`define OP_RET 5'd19

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_WIDTH-1:0] word_t;
	typedef logic [`CPU_DATA_WIDTH-1:0] inst_t;
	typedef logic [`CPU_INST_ADDR_WIDTH-1:0] inst_addr_t;
	typedef logic [`CPU_DATA_ADDR_WIDTH-1:0] data_addr_t;
	typedef logic [`CPU_REG_ADDR_WIDTH-1:0] reg_addr_t;

	// {zero, sign, overflow}
	typedef logic [2:0] flags_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_IMM
	} alu_op_t;

	// order follows the cond field encoding
	typedef enum logic [2:0] {
		COND_NE,
		COND_EQ,
		COND_GT,
		COND_LT,
		COND_GE,
		COND_LE,
		COND_OVER,
		COND_ALWAYS
	} branch_cond_t;

	// lli lands in the low half, lui in the high half, else whole word
	function automatic word_t merge_half(input word_t base, input word_t value,
			input logic lower, input logic upper);
		word_t merged;
		merged = value;
		if (lower)
			merged = {base[`CPU_DATA_WIDTH-1:`CPU_HALF_WIDTH], value[`CPU_HALF_WIDTH-1:0]};
		else if (upper)
			merged = {value[`CPU_HALF_WIDTH-1:0], base[`CPU_HALF_WIDTH-1:0]};
		return merged;
	endfunction

endpackage

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import cpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire redirect,
	input wire inst_addr_t redirect_pc,
	input wire link,
	input wire inst_addr_t link_pc,
	input wire ret,
	input wire stall,
	input wire inst_t imem_data,
	output inst_addr_t imem_addr,
	output inst_t if_id_inst,
	output inst_addr_t if_id_pc,
	output logic if_id_valid
);

	inst_addr_t pc;
	inst_addr_t link_reg;

	// instruction memory is word addressed
	assign imem_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			link_reg <= '0;
			if_id_valid <= 1'b0;
		end else begin
			if (redirect)
				pc <= redirect_pc;
			else if (ret)
				pc <= link_reg;
			else if (!stall)
				pc <= pc + 1'b1;

			if (link)
				link_reg <= link_pc;

			// the word fetched behind a taken branch is dropped
			if (redirect || ret)
				if_id_valid <= 1'b0;
			else if (!stall)
				if_id_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if_id_inst <= imem_data;
			if_id_pc <= pc;
		end
	end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module register_file import cpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire reg_addr_t rd_addr1,
	input wire reg_addr_t rd_addr2,
	input wire wr_en,
	input wire wr_lower,
	input wire wr_upper,
	input wire reg_addr_t wr_addr,
	input wire word_t wr_data,
	output word_t rd_data1,
	output word_t rd_data2
);

	word_t regs [`CPU_REG_COUNT];
	word_t wr_value;
	logic wr_active;

	// register 0 stays zero
	assign wr_active = wr_en && (wr_addr != '0);
	assign wr_value = merge_half(regs[wr_addr], wr_data, wr_lower, wr_upper);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_active) begin
			regs[wr_addr] <= wr_value;
		end
	end

	// same-cycle write passes straight to decode
	assign rd_data1 = (wr_active && rd_addr1 == wr_addr) ? wr_value : regs[rd_addr1];
	assign rd_data2 = (wr_active && rd_addr2 == wr_addr) ? wr_value : regs[rd_addr2];

	a_single_half: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr_lower && wr_upper));

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module decode_stage import cpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire inst_t if_id_inst,
	input wire inst_addr_t if_id_pc,
	input wire if_id_valid,
	input wire flags_t flags,
	input wire word_t rf_data1,
	input wire word_t rf_data2,
	output reg_addr_t rf_addr1,
	output reg_addr_t rf_addr2,
	output logic redirect,
	output inst_addr_t redirect_pc,
	output logic link,
	output inst_addr_t link_pc,
	output logic ret,
	output logic stall,
	output logic id_ex_valid,
	output alu_op_t id_ex_alu_op,
	output logic id_ex_use_imm,
	output logic id_ex_set_flags,
	output logic id_ex_load,
	output logic id_ex_store,
	output logic id_ex_wr_en,
	output logic id_ex_wr_lower,
	output logic id_ex_wr_upper,
	output reg_addr_t id_ex_rd,
	output reg_addr_t id_ex_rs1,
	output reg_addr_t id_ex_rs2,
	output word_t id_ex_op1,
	output word_t id_ex_op2,
	output word_t id_ex_imm
);

	logic [4:0] opcode;
	reg_addr_t rd_field;
	reg_addr_t rs1_field;
	reg_addr_t rs2_field;
	branch_cond_t cond;
	word_t imm;
	alu_op_t alu_op;
	logic op_valid, use_imm, set_flags, load, store, wr_en, wr_lower, wr_upper;
	logic use_rs1, use_rs2, is_branch, is_link, is_ret;
	logic flag_z, flag_s, flag_o;
	logic taken, hazard, issue;

	assign opcode = if_id_inst[31:27];
	assign rd_field = if_id_inst[26:22];
	assign rs1_field = if_id_inst[21:17];
	assign rs2_field = if_id_inst[16:12];
	assign cond = branch_cond_t'(if_id_inst[26:24]);
	assign imm = {{`CPU_HALF_WIDTH{if_id_inst[15]}}, if_id_inst[15:0]};
	assign {flag_z, flag_s, flag_o} = flags;

	// swo carries its store data register in the rd field
	assign rf_addr1 = rs1_field;
	assign rf_addr2 = store ? rd_field : rs2_field;

	//////////////////////////////////////////////////////////////////////////
	// opcode decoder

	always_comb begin
		op_valid = 1'b0;
		use_imm = 1'b0;
		set_flags = 1'b0;
		load = 1'b0;
		store = 1'b0;
		wr_en = 1'b0;
		wr_lower = 1'b0;
		wr_upper = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		is_branch = 1'b0;
		is_link = 1'b0;
		is_ret = 1'b0;
		case (opcode)
			`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_SLL, `OP_SRL, `OP_SRA: begin
				op_valid = 1'b1;
				set_flags = 1'b1;
				wr_en = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			`OP_ADDI, `OP_ANDI, `OP_ORI: begin
				op_valid = 1'b1;
				use_imm = 1'b1;
				set_flags = 1'b1;
				wr_en = 1'b1;
				use_rs1 = 1'b1;
			end
			`OP_LLI, `OP_LUI: begin
				op_valid = 1'b1;
				wr_en = 1'b1;
				wr_lower = (opcode == `OP_LLI);
				wr_upper = (opcode == `OP_LUI);
			end
			// store data arrives late through the memory-stage forward
			`OP_LWO, `OP_SWO: begin
				op_valid = 1'b1;
				use_imm = 1'b1;
				use_rs1 = 1'b1;
				load = (opcode == `OP_LWO);
				store = (opcode == `OP_SWO);
				wr_en = (opcode == `OP_LWO);
			end
			`OP_B, `OP_BL: begin
				is_branch = 1'b1;
				is_link = (opcode == `OP_BL);
			end
			`OP_RET: is_ret = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		case (opcode)
			`OP_SUB: alu_op = ALU_SUB;
			`OP_AND, `OP_ANDI: alu_op = ALU_AND;
			`OP_OR, `OP_ORI: alu_op = ALU_OR;
			`OP_XOR: alu_op = ALU_XOR;
			`OP_SLL: alu_op = ALU_SLL;
			`OP_SRL: alu_op = ALU_SRL;
			`OP_SRA: alu_op = ALU_SRA;
			`OP_LLI, `OP_LUI: alu_op = ALU_PASS_IMM;
			default: alu_op = ALU_ADD;
		endcase
	end

	//////////////////////////////////////////////////////////////////////////
	// branch resolution

	always_comb begin
		case (cond)
			COND_NE: taken = !flag_z;
			COND_EQ: taken = flag_z;
			COND_GT: taken = !flag_z && !flag_s;
			COND_LT: taken = !flag_z && flag_s;
			COND_GE: taken = flag_z || !flag_s;
			COND_LE: taken = flag_z || flag_s;
			COND_OVER: taken = flag_o;
			default: taken = 1'b1;
		endcase
	end

	assign redirect = if_id_valid && is_branch && taken;
	assign redirect_pc = if_id_pc + 1'b1 + imm[`CPU_INST_ADDR_WIDTH-1:0];
	assign link = redirect && is_link;
	assign link_pc = if_id_pc + 1'b1;
	assign ret = if_id_valid && is_ret;

	// loaded word is not ready until the load leaves memory
	assign hazard = if_id_valid && id_ex_valid && id_ex_load && (id_ex_rd != '0)
		&& ((use_rs1 && rs1_field == id_ex_rd) || (use_rs2 && rs2_field == id_ex_rd));
	assign stall = hazard;
	assign issue = if_id_valid && op_valid && !hazard;

	//////////////////////////////////////////////////////////////////////////
	// ID/EX register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex_valid <= 1'b0;
			id_ex_set_flags <= 1'b0;
			id_ex_load <= 1'b0;
			id_ex_store <= 1'b0;
			id_ex_wr_en <= 1'b0;
			id_ex_wr_lower <= 1'b0;
			id_ex_wr_upper <= 1'b0;
		end else begin
			id_ex_valid <= issue;
			id_ex_set_flags <= issue && set_flags;
			id_ex_load <= issue && load;
			id_ex_store <= issue && store;
			id_ex_wr_en <= issue && wr_en;
			id_ex_wr_lower <= issue && wr_lower;
			id_ex_wr_upper <= issue && wr_upper;
		end
	end

	always_ff @(posedge clk) begin
		id_ex_alu_op <= alu_op;
		id_ex_use_imm <= use_imm;
		id_ex_rd <= rd_field;
		id_ex_rs1 <= rs1_field;
		id_ex_rs2 <= rf_addr2;
		id_ex_op1 <= rf_data1;
		id_ex_op2 <= rf_data2;
		id_ex_imm <= imm;
	end

	// a stalled instruction waits in IF/ID for the next cycle
	a_stall_holds_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(if_id_pc) && $stable(if_id_inst));

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module execute_stage import cpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire id_ex_valid,
	input wire alu_op_t id_ex_alu_op,
	input wire id_ex_use_imm,
	input wire id_ex_set_flags,
	input wire id_ex_load,
	input wire id_ex_store,
	input wire id_ex_wr_en,
	input wire id_ex_wr_lower,
	input wire id_ex_wr_upper,
	input wire reg_addr_t id_ex_rd,
	input wire reg_addr_t id_ex_rs1,
	input wire reg_addr_t id_ex_rs2,
	input wire word_t id_ex_op1,
	input wire word_t id_ex_op2,
	input wire word_t id_ex_imm,
	input wire word_t mem_wb_result,
	input wire reg_addr_t mem_wb_rd,
	input wire mem_wb_wr_en,
	input wire mem_wb_wr_lower,
	input wire mem_wb_wr_upper,
	output flags_t flags,
	output logic ex_mem_valid,
	output word_t ex_mem_result,
	output word_t ex_mem_store_data,
	output logic ex_mem_load,
	output logic ex_mem_store,
	output reg_addr_t ex_mem_rd,
	output logic ex_mem_wr_en,
	output logic ex_mem_wr_lower,
	output logic ex_mem_wr_upper,
	output reg_addr_t ex_mem_rs2
);

	word_t fwd_op1, fwd_op2;
	word_t alu_a, alu_b, result;
	logic overflow, update;
	flags_t new_flags, flag_reg;

	// older MEM/WB value first so the newer EX/MEM value lands on top
	function automatic word_t forward(input reg_addr_t rs, input word_t reg_value);
		word_t value;
		value = reg_value;
		if (mem_wb_wr_en && rs != '0 && rs == mem_wb_rd)
			value = merge_half(value, mem_wb_result, mem_wb_wr_lower, mem_wb_wr_upper);
		// a load in EX/MEM has only its address so far
		if (ex_mem_valid && ex_mem_wr_en && !ex_mem_load && rs != '0 && rs == ex_mem_rd)
			value = merge_half(value, ex_mem_result, ex_mem_wr_lower, ex_mem_wr_upper);
		return value;
	endfunction

	always_comb begin
		fwd_op1 = forward(id_ex_rs1, id_ex_op1);
		fwd_op2 = forward(id_ex_rs2, id_ex_op2);
	end

	assign alu_a = fwd_op1;
	assign alu_b = id_ex_use_imm ? id_ex_imm : fwd_op2;

	//////////////////////////////////////////////////////////////////////////
	// ALU and flags

	always_comb begin
		overflow = 1'b0;
		case (id_ex_alu_op)
			ALU_ADD: begin
				result = alu_a + alu_b;
				overflow = (alu_a[`CPU_DATA_WIDTH-1] == alu_b[`CPU_DATA_WIDTH-1])
					&& (result[`CPU_DATA_WIDTH-1] != alu_a[`CPU_DATA_WIDTH-1]);
			end
			ALU_SUB: begin
				result = alu_a - alu_b;
				overflow = (alu_a[`CPU_DATA_WIDTH-1] != alu_b[`CPU_DATA_WIDTH-1])
					&& (result[`CPU_DATA_WIDTH-1] != alu_a[`CPU_DATA_WIDTH-1]);
			end
			ALU_AND: result = alu_a & alu_b;
			ALU_OR: result = alu_a | alu_b;
			ALU_XOR: result = alu_a ^ alu_b;
			ALU_SLL: result = alu_a << alu_b[`CPU_SHIFT_WIDTH-1:0];
			ALU_SRL: result = alu_a >> alu_b[`CPU_SHIFT_WIDTH-1:0];
			ALU_SRA: result = $signed(alu_a) >>> alu_b[`CPU_SHIFT_WIDTH-1:0];
			// half-word value merged at write-back
			ALU_PASS_IMM: result = id_ex_imm;
			default: result = '0;
		endcase
	end

	assign new_flags = {result == '0, result[`CPU_DATA_WIDTH-1], overflow};
	assign update = id_ex_valid && id_ex_set_flags;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			flag_reg <= '0;
		else if (update)
			flag_reg <= new_flags;
	end

	// a branch in decode sees the flags of the instruction right before it
	assign flags = update ? new_flags : flag_reg;

	//////////////////////////////////////////////////////////////////////////
	// EX/MEM register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem_valid <= 1'b0;
			ex_mem_load <= 1'b0;
			ex_mem_store <= 1'b0;
			ex_mem_wr_en <= 1'b0;
			ex_mem_wr_lower <= 1'b0;
			ex_mem_wr_upper <= 1'b0;
		end else begin
			ex_mem_valid <= id_ex_valid;
			ex_mem_load <= id_ex_valid && id_ex_load;
			ex_mem_store <= id_ex_valid && id_ex_store;
			ex_mem_wr_en <= id_ex_valid && id_ex_wr_en;
			ex_mem_wr_lower <= id_ex_valid && id_ex_wr_lower;
			ex_mem_wr_upper <= id_ex_valid && id_ex_wr_upper;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem_result <= result;
		ex_mem_store_data <= fwd_op2;
		ex_mem_rd <= id_ex_rd;
		ex_mem_rs2 <= id_ex_rs2;
	end

	a_load_or_store: assert property (@(posedge clk) disable iff (!rst_n)
		!(ex_mem_load && ex_mem_store));

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module memory_stage import cpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire ex_mem_valid,
	input wire word_t ex_mem_result,
	input wire word_t ex_mem_store_data,
	input wire ex_mem_load,
	input wire ex_mem_store,
	input wire reg_addr_t ex_mem_rd,
	input wire ex_mem_wr_en,
	input wire ex_mem_wr_lower,
	input wire ex_mem_wr_upper,
	input wire reg_addr_t ex_mem_rs2,
	input wire word_t dmem_rdata,
	output data_addr_t dmem_addr,
	output word_t dmem_wdata,
	output logic dmem_write,
	output logic mem_wb_valid,
	output word_t mem_wb_result,
	output reg_addr_t mem_wb_rd,
	output logic mem_wb_wr_en,
	output logic mem_wb_wr_lower,
	output logic mem_wb_wr_upper
);

	logic store_fwd;

	assign dmem_addr = ex_mem_result[`CPU_DATA_ADDR_WIDTH-1:0];
	assign dmem_write = ex_mem_valid && ex_mem_store;

	// a load directly ahead of the store hands over its word here
	assign store_fwd = mem_wb_valid && mem_wb_wr_en && (ex_mem_rs2 != '0)
		&& (ex_mem_rs2 == mem_wb_rd);
	assign dmem_wdata = store_fwd
		? merge_half(ex_mem_store_data, mem_wb_result, mem_wb_wr_lower, mem_wb_wr_upper)
		: ex_mem_store_data;

	// MEM/WB register feeding the register file write port
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb_valid <= 1'b0;
			mem_wb_wr_en <= 1'b0;
			mem_wb_wr_lower <= 1'b0;
			mem_wb_wr_upper <= 1'b0;
		end else begin
			mem_wb_valid <= ex_mem_valid;
			mem_wb_wr_en <= ex_mem_valid && ex_mem_wr_en;
			mem_wb_wr_lower <= ex_mem_valid && ex_mem_wr_lower;
			mem_wb_wr_upper <= ex_mem_valid && ex_mem_wr_upper;
		end
	end

	always_ff @(posedge clk) begin
		mem_wb_result <= ex_mem_load ? dmem_rdata : ex_mem_result;
		mem_wb_rd <= ex_mem_rd;
	end

endmodule

`default_nettype wire

//--- verilog/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu import cpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire inst_t imem_data,
	input wire word_t dmem_rdata,
	output inst_addr_t imem_addr,
	output data_addr_t dmem_addr,
	output word_t dmem_wdata,
	output logic dmem_write
);

	////////////////////////////////////////////////////////////////////////////
	// stage to stage wires

	// fetch and decode
	logic redirect, link, ret, stall;
	inst_addr_t redirect_pc, link_pc, if_id_pc;
	inst_t if_id_inst;
	logic if_id_valid;

	// register file read port
	reg_addr_t rf_addr1, rf_addr2;
	word_t rf_data1, rf_data2;

	// ID/EX and the flags back to decode
	flags_t flags;
	alu_op_t id_ex_alu_op;
	logic id_ex_valid, id_ex_use_imm, id_ex_set_flags, id_ex_load, id_ex_store;
	logic id_ex_wr_en, id_ex_wr_lower, id_ex_wr_upper;
	reg_addr_t id_ex_rd, id_ex_rs1, id_ex_rs2;
	word_t id_ex_op1, id_ex_op2, id_ex_imm;

	// EX/MEM
	logic ex_mem_valid, ex_mem_load, ex_mem_store;
	logic ex_mem_wr_en, ex_mem_wr_lower, ex_mem_wr_upper;
	word_t ex_mem_result, ex_mem_store_data;
	reg_addr_t ex_mem_rd, ex_mem_rs2;

	// MEM/WB, also the write-back port
	logic mem_wb_valid, mem_wb_wr_en, mem_wb_wr_lower, mem_wb_wr_upper;
	word_t mem_wb_result;
	reg_addr_t mem_wb_rd;

	////////////////////////////////////////////////////////////////////////////
	// stages

	fetch_stage u_fetch (.*);

	register_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr1(rf_addr1),
		.rd_addr2(rf_addr2),
		.wr_en(mem_wb_wr_en),
		.wr_lower(mem_wb_wr_lower),
		.wr_upper(mem_wb_wr_upper),
		.wr_addr(mem_wb_rd),
		.wr_data(mem_wb_result),
		.rd_data1(rf_data1),
		.rd_data2(rf_data2)
	);

	decode_stage u_decode (.*);

	execute_stage u_execute (.*);

	memory_stage u_memory (.*);

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst_n
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held for the first 4 cycles
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();

	localparam int MAX_CYCLES = 2000;
	localparam data_addr_t END_ADDR = 16'hffff;

	logic clk, gen_rst_n, run_rst_n, rst_n;
	inst_addr_t imem_addr;
	inst_t imem_data;
	data_addr_t dmem_addr;
	word_t dmem_wdata, dmem_rdata;
	logic dmem_write;

	inst_t imem [512];
	word_t dmem [65536];
	inst_t prog [$];
	data_addr_t log_addr [$];
	word_t log_data [$];
	data_addr_t exp_addr [$];
	word_t exp_data [$];
	logic end_seen;
	int cycles;

	clock_gen u_clock (.clk(clk), .rst_n(gen_rst_n));

	assign rst_n = gen_rst_n && run_rst_n;

	cpu UUT (
		.clk(clk),
		.rst_n(rst_n),
		.imem_data(imem_data),
		.dmem_rdata(dmem_rdata),
		.imem_addr(imem_addr),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_write(dmem_write)
	);

	////////////////////////////////////////////////////////////////////////////
	// memory models

	assign imem_data = imem[imem_addr[8:0]];
	assign dmem_rdata = dmem[dmem_addr];

	// stores sampled mid-cycle up to the end store
	always @(negedge clk) begin
		if (run_rst_n && !end_seen && dmem_write) begin
			dmem[dmem_addr] = dmem_wdata;
			if (dmem_addr == END_ADDR) begin
				end_seen = 1'b1;
			end else begin
				log_addr.push_back(dmem_addr);
				log_data.push_back(dmem_wdata);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: no end store after %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$fatal(1, "run stopped");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding and reference model

	function automatic inst_t r_type(logic [4:0] op, reg_addr_t rd, reg_addr_t rs1,
			reg_addr_t rs2);
		return {op, rd, rs1, rs2, 12'b0};
	endfunction

	function automatic inst_t i_type(logic [4:0] op, reg_addr_t rd, reg_addr_t rs1,
			logic [15:0] imm);
		return {op, rd, rs1, 1'b0, imm};
	endfunction

	function automatic inst_t branch(logic [4:0] op, logic [2:0] cond, logic [15:0] off);
		return {op, cond, 2'b0, 5'd0, 1'b0, off};
	endfunction

	function automatic inst_t store(reg_addr_t src, logic [15:0] addr);
		return i_type(`OP_SWO, src, 5'd0, addr);
	endfunction

	function automatic word_t alu_model(logic [4:0] op, word_t a, word_t b);
		word_t r;
		case (op)
			`OP_ADD, `OP_ADDI: r = a + b;
			`OP_SUB: r = a - b;
			`OP_AND, `OP_ANDI: r = a & b;
			`OP_OR, `OP_ORI: r = a | b;
			`OP_XOR: r = a ^ b;
			`OP_SLL: r = a << b[4:0];
			`OP_SRL: r = a >> b[4:0];
			`OP_SRA: r = $signed(a) >>> b[4:0];
			default: r = '0;
		endcase
		return r;
	endfunction

	// flags come from a - b
	function automatic logic taken_model(logic [2:0] cond, word_t a, word_t b);
		word_t r;
		logic z, s, o, t;
		r = a - b;
		z = (r == '0);
		s = r[31];
		o = (a[31] != b[31]) && (r[31] != a[31]);
		case (cond)
			3'd0: t = !z;
			3'd1: t = z;
			3'd2: t = !z && !s;
			3'd3: t = !z && s;
			3'd4: t = z || !s;
			3'd5: t = z || s;
			3'd6: t = o;
			default: t = 1'b1;
		endcase
		return t;
	endfunction

	task automatic emit(inst_t inst);
		prog.push_back(inst);
	endtask

	// lli then lui
	task automatic emit_const(reg_addr_t r, word_t v);
		emit(i_type(`OP_LLI, r, 5'd0, v[15:0]));
		emit(i_type(`OP_LUI, r, 5'd0, v[31:16]));
	endtask

	task automatic expect_store(data_addr_t a, word_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// run and compare

	task automatic check_value(string name, word_t got, word_t exp);
		assert (got == exp) else begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "run stopped");
		end
	endtask

	task automatic run_program(string name);
		@(negedge clk);
		run_rst_n = 1'b0;
		emit(store(5'd0, END_ADDR));
		for (int i = 0; i < 512; i++)
			imem[i] = (i < prog.size()) ? prog[i] : '0;
		log_addr.delete();
		log_data.delete();
		end_seen = 1'b0;
		repeat (2) @(negedge clk);
		// pc and the store strobe come out of reset cleared
		check_value("imem_addr", {16'h0, imem_addr}, 32'h0);
		check_value("dmem_write", {31'h0, dmem_write}, 32'h0);
		run_rst_n = 1'b1;
		while (!end_seen)
			@(posedge clk);
		assert (log_addr.size() == exp_addr.size()) else begin
			$display("%s: wrong number of stores, got %0d expected %0d", name,
				log_addr.size(), exp_addr.size());
			$display("Some tests failed");
			$fatal(1, "run stopped");
		end
		for (int i = 0; i < exp_addr.size(); i++) begin
			check_value("dmem_addr", {16'h0, log_addr[i]}, {16'h0, exp_addr[i]});
			check_value("dmem_wdata", log_data[i], exp_data[i]);
		end
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic alu_ops_test();
		logic [4:0] reg_ops [8];
		logic [4:0] imm_ops [3];
		word_t a, b, r;
		logic [15:0] imm;
		reg_ops = '{`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_SLL, `OP_SRL, `OP_SRA};
		imm_ops = '{`OP_ADDI, `OP_ANDI, `OP_ORI};
		for (int i = 0; i < 8; i++) begin
			a = $urandom;
			b = $urandom;
			r = alu_model(reg_ops[i], a, b);
			emit_const(5'd1, a);
			emit_const(5'd2, b);
			emit(r_type(reg_ops[i], 5'd3, 5'd1, 5'd2));
			// chained use of the fresh result
			emit(r_type(`OP_ADD, 5'd4, 5'd3, 5'd1));
			emit(store(5'd3, 16'h10 + 16'(2 * i)));
			emit(store(5'd4, 16'h11 + 16'(2 * i)));
			expect_store(16'h10 + 16'(2 * i), r);
			expect_store(16'h11 + 16'(2 * i), r + a);
		end
		for (int j = 0; j < 3; j++) begin
			a = $urandom;
			b = $urandom;
			imm = b[15:0];
			emit_const(5'd1, a);
			emit(i_type(imm_ops[j], 5'd3, 5'd1, imm));
			emit(store(5'd3, 16'h40 + 16'(j)));
			expect_store(16'h40 + 16'(j), alu_model(imm_ops[j], a, {{16{imm[15]}}, imm}));
		end
		run_program("alu");
	endtask

	task automatic load_store_test();
		word_t a;
		a = $urandom;
		emit_const(5'd1, a);
		emit(store(5'd1, 16'h20));
		emit(i_type(`OP_LWO, 5'd2, 5'd0, 16'h20));
		// load-use stall
		emit(r_type(`OP_ADD, 5'd3, 5'd2, 5'd0));
		emit(store(5'd3, 16'h21));
		emit(i_type(`OP_LWO, 5'd4, 5'd0, 16'h20));
		emit(store(5'd4, 16'h22));
		emit(i_type(`OP_ADDI, 5'd5, 5'd1, 16'h0001));
		emit(store(5'd5, 16'h23));
		emit(i_type(`OP_ADDI, 5'd6, 5'd0, 16'h0020));
		emit(i_type(`OP_LWO, 5'd7, 5'd6, 16'h0001));
		emit(store(5'd7, 16'h24));
		expect_store(16'h20, a);
		expect_store(16'h21, a);
		expect_store(16'h22, a);
		expect_store(16'h23, a + 1);
		expect_store(16'h24, a);
		run_program("load_store");
	endtask

	task automatic branch_test();
		word_t pa [4];
		word_t pb [4];
		int k;
		pa = '{32'd5, 32'd3, 32'd7, 32'h8000_0000};
		pb = '{32'd5, 32'd7, 32'd3, 32'd1};
		for (int p = 0; p < 4; p++) begin
			emit_const(reg_addr_t'(20 + 2 * p), pa[p]);
			emit_const(reg_addr_t'(21 + 2 * p), pb[p]);
		end
		emit(i_type(`OP_LLI, 5'd10, 5'd0, 16'h0a0a));
		emit(i_type(`OP_LLI, 5'd11, 5'd0, 16'h0b0b));
		for (int c = 0; c < 8; c++) begin
			for (int p = 0; p < 4; p++) begin
				k = c * 4 + p;
				emit(r_type(`OP_SUB, 5'd3, reg_addr_t'(20 + 2 * p), reg_addr_t'(21 + 2 * p)));
				emit(branch(`OP_B, 3'(c), 16'd2));
				// fall-through path
				emit(store(5'd10, 16'h100 + 16'(k)));
				emit(branch(`OP_B, 3'd7, 16'd1));
				emit(store(5'd11, 16'h100 + 16'(k)));
				expect_store(16'h100 + 16'(k),
					taken_model(3'(c), pa[p], pb[p]) ? 32'h0b0b : 32'h0a0a);
			end
		end
		run_program("branches");
	endtask

	task automatic call_return_test();
		emit(i_type(`OP_LLI, 5'd1, 5'd0, 16'd1));
		emit(i_type(`OP_LLI, 5'd2, 5'd0, 16'd2));
		emit(i_type(`OP_LLI, 5'd3, 5'd0, 16'd3));
		emit(branch(`OP_BL, 3'd7, 16'd3));
		emit(store(5'd2, 16'h201));
		emit(store(5'd0, END_ADDR));
		emit(store(5'd3, 16'h2fe));
		// subroutine
		emit(store(5'd1, 16'h200));
		emit(i_type(`OP_RET, 5'd0, 5'd0, 16'd0));
		emit(store(5'd3, 16'h2ff));
		expect_store(16'h200, 32'd1);
		expect_store(16'h201, 32'd2);
		run_program("call_return");
	endtask

	task automatic zero_halves_test();
		word_t v, w;
		v = $urandom;
		w = $urandom;
		emit(i_type(`OP_ADDI, 5'd0, 5'd0, 16'h0055));
		emit(i_type(`OP_LLI, 5'd0, 5'd0, 16'h1234));
		emit(r_type(`OP_ADD, 5'd1, 5'd0, 5'd0));
		emit(store(5'd0, 16'h300));
		emit(store(5'd1, 16'h301));
		emit_const(5'd2, v);
		emit(store(5'd2, 16'h302));
		emit(i_type(`OP_LLI, 5'd2, 5'd0, w[15:0]));
		emit(store(5'd2, 16'h303));
		emit(i_type(`OP_LUI, 5'd2, 5'd0, w[31:16]));
		emit(store(5'd2, 16'h304));
		expect_store(16'h300, 32'd0);
		expect_store(16'h301, 32'd0);
		expect_store(16'h302, v);
		expect_store(16'h303, {v[31:16], w[15:0]});
		expect_store(16'h304, w);
		run_program("zero_and_halves");
	endtask

	initial begin
		void'($urandom(32'h36007c55));
		run_rst_n = 1'b1;
		end_seen = 1'b0;
		cycles = 0;
		for (int i = 0; i < 512; i++)
			imem[i] = '0;
		for (int i = 0; i < 65536; i++)
			dmem[i] = '0;
		wait (gen_rst_n);
		alu_ops_test();
		load_store_test();
		branch_test();
		call_return_test();
		zero_halves_test();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu.sv
sim/clock_gen.sv
sim/cpu_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f cpu.f \
	&& { ./obj_dir/Vcpu_tb > sim.log 2>&1; cat sim.log; } \
	&& grep -q "All tests passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
